//--- axi_rd_xbar_ctrl.f
hw/xbar_pkg.sv
hw/ar_route_if.sv
hw/addr_range_decoder.sv
hw/ar_arbiter.sv
hw/rd_route_fsm.sv
hw/rd_data_router.sv
hw/axi_rd_xbar_ctrl.sv
sim/axi_rd_xbar_ctrl_chk.sv
sim/tb_axi_rd_xbar_ctrl.sv

//--- sim/tb_axi_rd_xbar_ctrl.sv
`timescale 1ns/1ps

module tb_axi_rd_xbar_ctrl;
    import xbar_pkg::*;

    localparam int TIMEOUT = 50;
    localparam int WINDOW  = 8;

    logic                   clkk;
    logic                   resett;
    addr_t                  slave_base  [NUM_SLAVES];
    addr_t                  slave_limit [NUM_SLAVES];
    addr_t                  m_addr;
    addr_t                  req_addr    [NUM_MASTERS];
    logic [NUM_MASTERS-1:0] m_arvalid;
    logic [NUM_SLAVES-1:0]  s_arready;
    logic [NUM_MASTERS-1:0] m_rready;
    logic [NUM_SLAVES-1:0]  s_rvalid;
    logic [NUM_SLAVES-1:0]  s_rlast;
    logic                   ar_grant_valid;
    master_idx_t            sel_master_addr;
    slave_idx_t             sel_slave_addr;
    slave_idx_t             sel_data    [NUM_MASTERS];
    master_idx_t            slave_owner [NUM_SLAVES];
    logic [NUM_SLAVES-1:0]  slave_busy;
    logic [15:0]            lfsr = 16'd38414;
    int                     timeouts;
    int                     seen_fails;
    int                     tests_ok;
    int                     tests_bad;

    // External address mux follows the arbiter's master select
    assign m_addr = req_addr[sel_master_addr];

    axi_rd_xbar_ctrl dut (.*);

    always #2 clkk = ~clkk;

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic tick();
        @(posedge clkk);
        #1;
    endtask

    task automatic accept(input int m, input int k);
        int n;
        int gap;
        n = 0;
        while (!(ar_grant_valid && sel_master_addr == master_idx_t'(m)) && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (n == TIMEOUT) begin
            $display("Timeout: master %0d never received an address grant", m);
            timeouts++;
        end
        // Slave holds off the address for a few cycles
        gap = take_bits(2);
        repeat (gap) tick();
        s_arready[k] = 1'b1;
        tick();
        s_arready    = '0;
        m_arvalid[m] = 1'b0;
    endtask

    task automatic finish_read(input int m, input int k);
        int n;
        int stall;
        s_rvalid[k] = 1'b1;
        s_rlast[k]  = 1'b1;
        stall = take_bits(2) + 1;
        repeat (stall) tick();
        m_rready[m] = 1'b1;
        n = 0;
        while (slave_busy[k] && n < TIMEOUT) begin
            tick();
            n++;
        end
        if (n == TIMEOUT) begin
            $display("Timeout: slave %0d stayed busy after its last beat", k);
            timeouts++;
        end
        s_rvalid[k] = 1'b0;
        s_rlast[k]  = 1'b0;
        m_rready[m] = 1'b0;
    endtask

    task automatic end_test(input string name);
        int fresh;
        fresh = dut.u_chk.fail_count - seen_fails;
        if (fresh != 0 || timeouts != 0) begin
            $display("Fail at %0d ns: %s, %0d assertion failures, %0d timeouts",
                     $time, name, fresh, timeouts);
            tests_bad++;
        end else begin
            $display("ok: %s", name);
            tests_ok++;
        end
        seen_fails = dut.u_chk.fail_count;
        timeouts   = 0;
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        int m;
        int k;
        clkk       = 1'b0;
        resett     = 1'b0;
        m_arvalid  = '0;
        s_arready  = '0;
        m_rready   = '0;
        s_rvalid   = '0;
        s_rlast    = '0;
        timeouts   = 0;
        seen_fails = 0;
        tests_ok   = 0;
        tests_bad  = 0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            // Slot 3 stays unmapped, slave 3 sits one slot higher
            slave_base[i]  = addr_t'((i < 3 ? i : i + 1) << 16);
            slave_limit[i] = slave_base[i] + 32'h0000_ffff;
        end
        req_addr[0] = '0;
        req_addr[1] = '0;
        repeat (5) tick();
        resett = 1'b1;
        tick();
        end_test("reset");

        req_addr[0] = slave_base[1] + take_bits(16);
        req_addr[1] = slave_base[2] + take_bits(16);
        m_arvalid   = 2'b11;
        accept(0, 1);
        accept(1, 2);
        end_test("priority and two routes in flight");

        // Master 0 still reads slave 1 while master 1 asks for slave 1
        finish_read(1, 2);
        req_addr[0] = slave_base[0] + take_bits(16);
        req_addr[1] = slave_base[1] + take_bits(16);
        m_arvalid   = 2'b11;
        repeat (WINDOW) tick();
        m_arvalid   = '0;
        // Master 0 alone asks for free slave 0 while its own read is open
        m_arvalid   = 2'b01;
        repeat (WINDOW) tick();
        m_arvalid   = '0;
        finish_read(0, 1);
        end_test("busy refusal and last beat");

        req_addr[0] = 32'h0003_0000 + take_bits(16);
        m_arvalid   = 2'b01;
        repeat (WINDOW) tick();
        m_arvalid   = '0;
        end_test("unmapped refusal");

        for (int i = 0; i < 12; i++) begin
            m = take_bits(1);
            k = take_bits(2);
            req_addr[m]  = slave_base[k] + take_bits(16);
            m_arvalid[m] = 1'b1;
            accept(m, k);
            finish_read(m, k);
        end
        end_test("random single reads");

        $display("Tests passed %0d, failed %0d", tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- sim/axi_rd_xbar_ctrl_chk.sv
`timescale 1ns/1ps

module axi_rd_xbar_ctrl_chk (
    input logic                             clkk,
    input logic                             resett,
    input xbar_pkg::addr_t                  slave_base  [xbar_pkg::NUM_SLAVES],
    input xbar_pkg::addr_t                  slave_limit [xbar_pkg::NUM_SLAVES],
    input xbar_pkg::addr_t                  m_addr,
    input logic [xbar_pkg::NUM_MASTERS-1:0] m_arvalid,
    input logic [xbar_pkg::NUM_SLAVES-1:0]  s_arready,
    input logic [xbar_pkg::NUM_MASTERS-1:0] m_rready,
    input logic [xbar_pkg::NUM_SLAVES-1:0]  s_rvalid,
    input logic [xbar_pkg::NUM_SLAVES-1:0]  s_rlast,
    input logic                             ar_grant_valid,
    input xbar_pkg::master_idx_t            sel_master_addr,
    input xbar_pkg::slave_idx_t             sel_slave_addr,
    input xbar_pkg::slave_idx_t             sel_data    [xbar_pkg::NUM_MASTERS],
    input xbar_pkg::master_idx_t            slave_owner [xbar_pkg::NUM_SLAVES],
    input logic [xbar_pkg::NUM_SLAVES-1:0]  slave_busy
);
    import xbar_pkg::*;

    int                     fail_count = 0;
    logic                   ref_hit;
    slave_idx_t             ref_slave;
    logic [NUM_MASTERS-1:0] m_busy;

    task automatic record_failure(input string what);
        fail_count++;
        $error("%s", what);
    endtask

    // Reference lookup, first inclusive range in ascending order
    always_comb begin
        ref_hit   = 1'b0;
        ref_slave = '0;
        for (int k = 0; k < NUM_SLAVES; k++) begin
            if (!ref_hit && m_addr >= slave_base[k] && m_addr <= slave_limit[k]) begin
                ref_hit   = 1'b1;
                ref_slave = slave_idx_t'(k);
            end
        end
    end

    // A master is busy when it owns a busy slave
    always_comb begin
        m_busy = '0;
        for (int k = 0; k < NUM_SLAVES; k++) begin
            if (slave_busy[k]) begin
                m_busy[slave_owner[k]] = 1'b1;
            end
        end
    end

    // ============================================================
    // Address channel
    // ============================================================
    a_reset: assert property (@(posedge clkk)
        (!resett || $rose(resett)) |-> (!ar_grant_valid && slave_busy == '0))
        else record_failure("grant or busy flag set around reset");

    a_priority: assert property (@(posedge clkk) disable iff (!resett)
        (!ar_grant_valid && m_arvalid == 2'b11 && slave_busy == '0 && ref_hit)
        |=> (ar_grant_valid && sel_master_addr == 1'b0))
        else record_failure("master 0 was not granted first");

    a_decode: assert property (@(posedge clkk) disable iff (!resett)
        ar_grant_valid |-> (ref_hit && sel_slave_addr == ref_slave))
        else record_failure("granted slave differs from range lookup");

    a_hold: assert property (@(posedge clkk) disable iff (!resett)
        (ar_grant_valid && m_arvalid[sel_master_addr] && !s_arready[sel_slave_addr])
        |=> (ar_grant_valid && $stable(sel_master_addr) && $stable(sel_slave_addr)))
        else record_failure("grant not held while slave not ready");

    a_refuse: assert property (@(posedge clkk) disable iff (!resett)
        (!ar_grant_valid && (!ref_hit || slave_busy[ref_slave] ||
            !((m_arvalid[0] && !m_busy[0]) || (m_arvalid[1] && !m_busy[1]))))
        |=> !ar_grant_valid)
        else record_failure("grant given to unmapped, busy or reading request");

    // ============================================================
    // Data routing
    // ============================================================
    a_route_start: assert property (@(posedge clkk) disable iff (!resett)
        (ar_grant_valid && m_arvalid[sel_master_addr] && s_arready[sel_slave_addr])
        |=> ((sel_data[$past(sel_master_addr)] == $past(sel_slave_addr)) &&
            slave_busy[$past(sel_slave_addr)] &&
            (slave_owner[$past(sel_slave_addr)] == $past(sel_master_addr))))
        else record_failure("accepted address did not start its route");

    // Last beat frees the slave only when the owner takes it
    for (genvar k = 0; k < NUM_SLAVES; k++) begin : g_last
        a_last_beat: assert property (@(posedge clkk) disable iff (!resett)
            (slave_busy[k] && s_rvalid[k] && s_rlast[k])
            |=> (slave_busy[k] == !$past(m_rready[slave_owner[k]])))
            else record_failure("slave busy flag wrong after last beat");
    end

endmodule

bind axi_rd_xbar_ctrl axi_rd_xbar_ctrl_chk u_chk (.*);

//--- hw/axi_rd_xbar_ctrl.sv
`timescale 1ns/1ps

module axi_rd_xbar_ctrl (
    input  logic                             clkk,
    input  logic                             resett,
    input  xbar_pkg::addr_t                  slave_base  [xbar_pkg::NUM_SLAVES],
    input  xbar_pkg::addr_t                  slave_limit [xbar_pkg::NUM_SLAVES],
    input  xbar_pkg::addr_t                  m_addr,
    input  logic [xbar_pkg::NUM_MASTERS-1:0] m_arvalid,
    input  logic [xbar_pkg::NUM_SLAVES-1:0]  s_arready,
    input  logic [xbar_pkg::NUM_MASTERS-1:0] m_rready,
    input  logic [xbar_pkg::NUM_SLAVES-1:0]  s_rvalid,
    input  logic [xbar_pkg::NUM_SLAVES-1:0]  s_rlast,
    output logic                             ar_grant_valid,
    output xbar_pkg::master_idx_t            sel_master_addr,
    output xbar_pkg::slave_idx_t             sel_slave_addr,
    output xbar_pkg::slave_idx_t             sel_data    [xbar_pkg::NUM_MASTERS],
    output xbar_pkg::master_idx_t            slave_owner [xbar_pkg::NUM_SLAVES],
    output logic [xbar_pkg::NUM_SLAVES-1:0]  slave_busy
);
    import xbar_pkg::*;

    logic       addr_hit;
    slave_idx_t hit_slave;

    // Grant and busy handoff between address and data side
    ar_route_if route_if ();

    addr_range_decoder u_decoder (
        .addr        (m_addr),
        .slave_base  (slave_base),
        .slave_limit (slave_limit),
        .addr_hit    (addr_hit),
        .hit_slave   (hit_slave)
    );

    ar_arbiter u_arbiter (
        .clkk            (clkk),
        .resett          (resett),
        .m_arvalid       (m_arvalid),
        .s_arready       (s_arready),
        .addr_hit        (addr_hit),
        .hit_slave       (hit_slave),
        .route           (route_if.arbiter),
        .ar_grant_valid  (ar_grant_valid),
        .sel_master_addr (sel_master_addr),
        .sel_slave_addr  (sel_slave_addr)
    );

    rd_data_router u_router (
        .clkk        (clkk),
        .resett      (resett),
        .m_rready    (m_rready),
        .s_rvalid    (s_rvalid),
        .s_rlast     (s_rlast),
        .route       (route_if.router),
        .sel_data    (sel_data),
        .slave_owner (slave_owner)
    );

    assign slave_busy = route_if.slave_busy;

endmodule

//--- hw/rd_data_router.sv
`timescale 1ns/1ps

module rd_data_router (
    input  logic                             clkk,
    input  logic                             resett,
    input  logic [xbar_pkg::NUM_MASTERS-1:0] m_rready,
    input  logic [xbar_pkg::NUM_SLAVES-1:0]  s_rvalid,
    input  logic [xbar_pkg::NUM_SLAVES-1:0]  s_rlast,
    ar_route_if.router                       route,
    output xbar_pkg::slave_idx_t             sel_data    [xbar_pkg::NUM_MASTERS],
    output xbar_pkg::master_idx_t            slave_owner [xbar_pkg::NUM_SLAVES]
);
    import xbar_pkg::*;

    logic [NUM_MASTERS-1:0] reading;
    logic [NUM_SLAVES-1:0]  busy_vec;

    // One route per master, started by its own accepted address
    for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_route
        rd_route_fsm u_route (
            .clkk        (clkk),
            .resett      (resett),
            .start       (route.ar_done && (route.ar_master == master_idx_t'(m))),
            .start_slave (route.ar_slave),
            .rready      (m_rready[m]),
            .s_rvalid    (s_rvalid),
            .s_rlast     (s_rlast),
            .reading     (reading[m]),
            .cur_slave   (sel_data[m])
        );
    end

    // ============================================================
    // Per slave busy and owner
    // ============================================================
    always_comb begin
        for (int k = 0; k < NUM_SLAVES; k++) begin
            busy_vec[k]    = 1'b0;
            slave_owner[k] = '0;
            for (int m = NUM_MASTERS - 1; m >= 0; m--) begin
                if (reading[m] && (sel_data[m] == slave_idx_t'(k))) begin
                    busy_vec[k]    = 1'b1;
                    slave_owner[k] = master_idx_t'(m);
                end
            end
        end
    end

    assign route.master_busy = reading;
    assign route.slave_busy  = busy_vec;

endmodule

//--- hw/rd_route_fsm.sv
`timescale 1ns/1ps

module rd_route_fsm (
    input  logic                            clkk,
    input  logic                            resett,
    input  logic                            start,
    input  xbar_pkg::slave_idx_t            start_slave,
    input  logic                            rready,
    input  logic [xbar_pkg::NUM_SLAVES-1:0] s_rvalid,
    input  logic [xbar_pkg::NUM_SLAVES-1:0] s_rlast,
    output logic                            reading,
    output xbar_pkg::slave_idx_t            cur_slave
);
    import xbar_pkg::*;

    rd_state_t  state;
    rd_state_t  next_state;
    slave_idx_t next_slave;
    logic       last_beat;

    // Last beat taken from the slave this master addressed
    assign last_beat = rready && s_rvalid[cur_slave] && s_rlast[cur_slave];

    // ============================================================
    // Route state machine
    // ============================================================
    always_comb begin
        next_state = state;
        next_slave = cur_slave;
        case (state)
            rd_idle: begin
                if (start) begin
                    next_state = rd_reading;
                    next_slave = start_slave;
                end
            end
            rd_reading: begin
                // Stalls here for as long as rready stays low
                if (last_beat) begin
                    next_state = rd_idle;
                end
            end
            default: next_state = rd_idle;
        endcase
    end

    always_ff @(posedge clkk or negedge resett) begin
        if (!resett) begin
            state     <= rd_idle;
            cur_slave <= '0;
        end else begin
            state     <= next_state;
            cur_slave <= next_slave;
        end
    end

    assign reading = (state == rd_reading);

endmodule

//--- hw/ar_arbiter.sv
`timescale 1ns/1ps

module ar_arbiter (
    input  logic                             clkk,
    input  logic                             resett,
    input  logic [xbar_pkg::NUM_MASTERS-1:0] m_arvalid,
    input  logic [xbar_pkg::NUM_SLAVES-1:0]  s_arready,
    input  logic                             addr_hit,
    input  xbar_pkg::slave_idx_t             hit_slave,
    ar_route_if.arbiter                      route,
    output logic                             ar_grant_valid,
    output xbar_pkg::master_idx_t            sel_master_addr,
    output xbar_pkg::slave_idx_t             sel_slave_addr
);
    import xbar_pkg::*;

    ar_state_t   state;
    ar_state_t   next_state;
    logic        cand_valid;
    master_idx_t cand_master;
    master_idx_t grant_master;
    logic        slave_free;
    logic        grant_ok;
    logic        handshake;

    // ============================================================
    // Candidate selection, master 0 first
    // ============================================================
    always_comb begin
        cand_valid  = 1'b0;
        cand_master = 1'b0;
        if (m_arvalid[0] && !route.master_busy[0]) begin
            cand_valid = 1'b1;
        end else if (m_arvalid[1] && !route.master_busy[1]) begin
            cand_valid  = 1'b1;
            cand_master = 1'b1;
        end
    end

    assign grant_master = (state == ar_grant_m1) ? 1'b1 : 1'b0;
    assign slave_free   = !route.slave_busy[hit_slave];

    // Grant survives only while the request and its target stay valid
    assign grant_ok  = addr_hit && slave_free && m_arvalid[grant_master];
    assign handshake = grant_ok && s_arready[hit_slave];

    always_comb begin
        next_state = state;
        case (state)
            ar_idle: begin
                if (cand_valid && addr_hit && slave_free) begin
                    next_state = cand_master ? ar_grant_m1 : ar_grant_m0;
                end
            end
            ar_grant_m0, ar_grant_m1: begin
                // Leave on the accepted address or on a withdrawn request
                if (!grant_ok || handshake) begin
                    next_state = ar_idle;
                end
            end
            default: next_state = ar_idle;
        endcase
    end

    always_ff @(posedge clkk or negedge resett) begin
        if (!resett) begin
            state <= ar_idle;
        end else begin
            state <= next_state;
        end
    end

    // ============================================================
    // Mux selects and accepted address report
    // ============================================================
    assign ar_grant_valid  = (state == ar_grant_m0) || (state == ar_grant_m1);
    assign sel_master_addr = ar_grant_valid ? grant_master : cand_master;
    assign sel_slave_addr  = ar_grant_valid ? hit_slave : '0;

    assign route.ar_done   = ar_grant_valid && handshake;
    assign route.ar_master = grant_master;
    assign route.ar_slave  = hit_slave;

endmodule

//--- hw/addr_range_decoder.sv
`timescale 1ns/1ps

module addr_range_decoder (
    input  xbar_pkg::addr_t      addr,
    input  xbar_pkg::addr_t      slave_base  [xbar_pkg::NUM_SLAVES],
    input  xbar_pkg::addr_t      slave_limit [xbar_pkg::NUM_SLAVES],
    output logic                 addr_hit,
    output xbar_pkg::slave_idx_t hit_slave
);
    import xbar_pkg::*;

    logic [NUM_SLAVES-1:0] in_range;

    // Both bounds are inclusive
    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            in_range[i] = (addr >= slave_base[i]) && (addr <= slave_limit[i]);
        end
    end

    // ============================================================
    // Lowest numbered match wins
    // ============================================================
    always_comb begin
        addr_hit  = 1'b0;
        hit_slave = '0;
        // Walk downward so the lowest index is written last
        for (int i = NUM_SLAVES - 1; i >= 0; i--) begin
            if (in_range[i]) begin
                addr_hit  = 1'b1;
                hit_slave = slave_idx_t'(i);
            end
        end
    end

endmodule

//--- hw/ar_route_if.sv
`timescale 1ns/1ps

interface ar_route_if;
    import xbar_pkg::*;

    // Accepted address, valid for one cycle
    logic                   ar_done;
    master_idx_t            ar_master;
    slave_idx_t             ar_slave;

    // Route status fed back to the arbiter
    logic [NUM_MASTERS-1:0] master_busy;
    logic [NUM_SLAVES-1:0]  slave_busy;

    modport arbiter (
        output ar_done,
        output ar_master,
        output ar_slave,
        input  master_busy,
        input  slave_busy
    );

    modport router (
        input  ar_done,
        input  ar_master,
        input  ar_slave,
        output master_busy,
        output slave_busy
    );

endinterface

//--- hw/xbar_pkg.sv
package xbar_pkg;

    // ============================================================
    // Bus dimensions
    // ============================================================
    localparam int NUM_MASTERS = 2;
    localparam int NUM_SLAVES  = 4;
    localparam int ADDR_W      = 32;

    // ============================================================
    // Meaningful widths
    // ============================================================
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [1:0]        slave_idx_t;
    typedef logic              master_idx_t;

    // Address channel arbiter states
    typedef enum logic [1:0] {
        ar_idle     = 2'b00,
        ar_grant_m0 = 2'b01,
        ar_grant_m1 = 2'b10
    } ar_state_t;

    // Read data route states, the slave index is kept apart
    typedef enum logic {
        rd_idle    = 1'b0,
        rd_reading = 1'b1
    } rd_state_t;

endpackage
